// ==== sim.f ====
+incdir+hw
hw/msg_pkg.sv
hw/layer_sched_pkg.sv
hw/page_align_sched.sv
hw/page_align_lane.sv
hw/page_align_top.sv
test/page_align_checker.sv
test/tb_page_align.sv

// ==== Makefile ====
# Verilator simulation of the page alignment bank.

SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_page_align
FILE_LIST = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = *** TEST PASSED ***

.PHONY: sim clean

# pass only if the log holds the pass line.
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_page_align.sv ====
`timescale 1ns/1ps
`include "page_align_macros.svh"

module tb_page_align
	import msg_pkg::*;
	import layer_sched_pkg::*;
;

	localparam int clk_period = 100;
	localparam int drive_delay = 1;
	localparam int reset_cycles = 2;
	localparam int run_cycles = 2000;
	localparam int mid_reset_at = 1000; // second reset inside the run.
	localparam int timeout_cycles = run_cycles + reset_cycles + 98;
	localparam logic [15:0] lfsr_seed = 16'd54665;

	logic          sys_clk = 1'b0;
	logic          rst;
	layer_status_t layer_status;
	logic          first_row_chunk;
	msg_bank_t     msg_in;
	msg_bank_t     msg_out;

	int          error_count;
	int          check_count;
	logic        coverage_ok;
	int          cycle_count = 0;
	logic [15:0] lfsr_state;

	always #(clk_period / 2) sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
	end

	page_align_top i_page_align_top (
		.sys_clk         (sys_clk),
		.rst             (rst),
		.layer_status    (layer_status),
		.first_row_chunk (first_row_chunk),
		.msg_in          (msg_in),
		.msg_out         (msg_out)
	);

	page_align_checker #(.clk_period(clk_period)) i_page_align_checker (
		.sys_clk         (sys_clk),
		.rst             (rst),
		.layer_status    (layer_status),
		.first_row_chunk (first_row_chunk),
		.msg_in          (msg_in),
		.msg_out         (msg_out),
		.error_count     (error_count),
		.check_count     (check_count),
		.coverage_ok     (coverage_ok)
	);

	// ============================================================
	// random source
	// ============================================================

	// x^16 + x^14 + x^13 + x^11 + 1, shifting right.
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	task automatic take_bits(input int count, output logic [63:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits[i] = lfsr_state[0]; // one step per bit.
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic drive_random_inputs();
		logic [63:0] bits;
		take_bits(2, bits);
		case (bits[1:0])
			2'd0: layer_status = 3'b000; // idle.
			2'd1: layer_status = 3'b001;
			2'd2: layer_status = 3'b010;
			default: layer_status = 3'b100;
		endcase
		take_bits(1, bits);
		first_row_chunk = bits[0];
		take_bits(64, bits);
		msg_in = bits;
	endtask

	// ============================================================
	// run control
	// ============================================================

	task automatic finish_run(input logic timed_out);
		if (!coverage_ok) begin
			$display("random stimulus missed a delay command or a none to two tap change");
		end
		$display("checks %0d, errors %0d", check_count, error_count);
		if (!timed_out && error_count == 0 && coverage_ok) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		layer_status = '0;
		first_row_chunk = 1'b0;
		msg_in = '0;
		lfsr_state = lfsr_seed;
		repeat (reset_cycles) @(posedge sys_clk);
		for (int i = 0; i < run_cycles; i++) begin
			#drive_delay;
			rst = (i >= mid_reset_at) && (i < mid_reset_at + reset_cycles);
			drive_random_inputs();
			@(posedge sys_clk);
		end
		finish_run(1'b0);
	end

	initial begin
		while (cycle_count < timeout_cycles) @(posedge sys_clk);
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		finish_run(1'b1);
	end

endmodule

// ==== test/page_align_checker.sv ====
`timescale 1ns/1ps
`include "page_align_macros.svh"

module page_align_checker
	import msg_pkg::*;
	import layer_sched_pkg::*;
#(
	parameter int clk_period = 100
) (
	input  logic          sys_clk,
	input  logic          rst,
	input  layer_status_t layer_status,
	input  logic          first_row_chunk,
	input  msg_bank_t     msg_in,
	input  msg_bank_t     msg_out,
	output int            error_count,
	output int            check_count,
	output logic          coverage_ok
);

	localparam int check_lead = 5; // compare just before the edge.

	msg_bank_t   hist_one; // input of one cycle ago.
	msg_bank_t   hist_two;
	logic [3:0][2:0] seen_cmd; // group by command.
	logic        seen_jump;
	delay_cmd_t  prev_cmd [`LANE_NUM];

	assign coverage_ok = (&seen_cmd[1]) && (&seen_cmd[2]) && (&seen_cmd[3]) && seen_jump;

	// ============================================================
	// reference model
	// ============================================================

	function automatic delay_cmd_t expected_cmd(input lane_group_t grp,
			input layer_status_t layer, input logic first);
		delay_cmd_t cmd;
		cmd = delay_none;
		case (grp)
			group_2_3: begin
				if (layer[2] && first) cmd = delay_two;
				else if (layer[0] || layer[1]) cmd = delay_one;
			end
			group_3_2: begin
				if ((layer[0] || layer[1]) && first) cmd = delay_two;
				else if (layer[2]) cmd = delay_one;
			end
			group_4_1: begin
				if (layer[1] && first) cmd = delay_two;
				else if (layer[0] || layer[2]) cmd = delay_one;
			end
			default: cmd = delay_two; // fixed lanes.
		endcase
		return cmd;
	endfunction

	task automatic compare_lanes();
		lane_group_t grp;
		delay_cmd_t  cmd;
		msg_t        expected;
		for (int n = 0; n < `LANE_NUM; n++) begin
			grp = lane_group_map[n];
			cmd = expected_cmd(grp, layer_status, first_row_chunk);
			case (cmd)
				delay_none: expected = msg_in[n];
				delay_one:  expected = hist_one[n];
				default:    expected = hist_two[n];
			endcase
			check_count++;
			if (msg_out[n] !== expected) begin
				error_count++;
				$display("error: %0d ns msg_out[%0d] expected %h actual %h",
					$time, n, expected, msg_out[n]);
			end
			seen_cmd[int'(grp)][int'(cmd)] = 1'b1;
			if (prev_cmd[n] == delay_none && cmd == delay_two) seen_jump = 1'b1;
			prev_cmd[n] = cmd;
		end
	endtask

	// ============================================================
	// sampling
	// ============================================================

	initial begin
		error_count = 0;
		check_count = 0;
		hist_one = '0;
		hist_two = '0;
		seen_cmd = '0;
		seen_jump = 1'b0;
		for (int n = 0; n < `LANE_NUM; n++) begin
			prev_cmd[n] = delay_two;
		end
		forever begin
			@(posedge sys_clk);
			if (rst) begin
				hist_one = '0; // stages cleared.
				hist_two = '0;
			end else begin
				hist_two = hist_one;
				hist_one = msg_in;
			end
			#(clk_period - check_lead);
			if (!rst) compare_lanes();
		end
	end

endmodule

// ==== hw/page_align_top.sv ====
`timescale 1ns/1ps
`include "page_align_macros.svh"

module page_align_top
	import msg_pkg::*;
	import layer_sched_pkg::*;
(
	input  logic          sys_clk,
	input  logic          rst,
	input  layer_status_t layer_status,
	input  logic          first_row_chunk,
	input  msg_bank_t     msg_in,
	output msg_bank_t     msg_out
);

	lane_cmd_t lane_cmd; // one delay command per lane.

	// ============================================================
	// schedule decode
	// ============================================================

	page_align_sched i_page_align_sched (
		.sys_clk         (sys_clk),
		.rst             (rst),
		.layer_status    (layer_status),
		.first_row_chunk (first_row_chunk),
		.lane_cmd        (lane_cmd)
	);

	// ============================================================
	// lane bank
	// ============================================================

	// every lane is the same delay line, only its command differs.
	for (genvar n = 0; n < `LANE_NUM; n++) begin : g_lane
		page_align_lane i_page_align_lane (
			.sys_clk         (sys_clk),
			.rst             (rst),
			.cmd             (lane_cmd[n]),
			.align_target_in (msg_in[n]),
			.align_out       (msg_out[n])
		);
	end

endmodule

// ==== hw/page_align_lane.sv ====
`timescale 1ns/1ps
`include "page_align_macros.svh"

module page_align_lane
	import msg_pkg::*;
	import layer_sched_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst,
	input  delay_cmd_t cmd,
	input  msg_t       align_target_in,
	output msg_t       align_out
);

	// stage[0] holds last cycle's input, stage[1] the one before.
	msg_t stage [`ALIGN_DEPTH];

	// ============================================================
	// delay line
	// ============================================================

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			for (int i = 0; i < `ALIGN_DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= align_target_in; // always shifts.
			for (int i = 1; i < `ALIGN_DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// ============================================================
	// output tap
	// ============================================================

	// tap may move every cycle, history keeps shifting underneath.
	always_comb begin
		case (cmd)
			delay_none: begin
				align_out = align_target_in; // same cycle pass-through.
			end
			delay_one: begin
				align_out = stage[0];
			end
			delay_two: begin
				align_out = stage[1];
			end
			default: begin
				align_out = stage[`ALIGN_DEPTH-1]; // deepest tap.
			end
		endcase
	end

	// decoder must never hand out the spare encoding.
	a_cmd_legal: assert property (
		@(posedge sys_clk) disable iff (rst)
			cmd inside {delay_none, delay_one, delay_two}
	) else $error("illegal delay command %b", cmd);

endmodule

// ==== hw/page_align_sched.sv ====
`timescale 1ns/1ps
`include "page_align_macros.svh"

module page_align_sched
	import layer_sched_pkg::*;
(
	input  logic          sys_clk,
	input  logic          rst,
	input  layer_status_t layer_status,
	input  logic          first_row_chunk,
	output lane_cmd_t     lane_cmd
);

	logic layer_0;
	logic layer_1;
	logic layer_2;

	delay_cmd_t cmd_2_3;
	delay_cmd_t cmd_3_2;
	delay_cmd_t cmd_4_1;

	assign layer_0 = layer_status[0];
	assign layer_1 = layer_status[1];
	assign layer_2 = layer_status[2];

	// ============================================================
	// per group delay decode
	// ============================================================

	// first row chunk of a layer needs the deeper tap
	always_comb begin
		if (layer_2 && first_row_chunk) begin
			cmd_2_3 = delay_two;
		end else if (layer_0 || layer_1) begin
			cmd_2_3 = delay_one;
		end else begin
			cmd_2_3 = delay_none;
		end

		if ((layer_0 || layer_1) && first_row_chunk) begin
			cmd_3_2 = delay_two;
		end else if (layer_2) begin
			cmd_3_2 = delay_one;
		end else begin
			cmd_3_2 = delay_none;
		end

		if (layer_1 && first_row_chunk) begin
			cmd_4_1 = delay_two;
		end else if (layer_0 || layer_2) begin
			cmd_4_1 = delay_one;
		end else begin
			cmd_4_1 = delay_none;
		end
	end

	// fan out by lane group.
	always_comb begin
		for (int n = 0; n < `LANE_NUM; n++) begin
			case (lane_group_map[n])
				group_2_3: lane_cmd[n] = cmd_2_3;
				group_3_2: lane_cmd[n] = cmd_3_2;
				group_4_1: lane_cmd[n] = cmd_4_1;
				default:   lane_cmd[n] = delay_two; // fixed lanes.
			endcase
		end
	end

	// only one layer may be in flight at a time.
	a_layer_onehot: assert property (
		@(posedge sys_clk) disable iff (rst) $onehot0(layer_status)
	) else $error("layer_status not one-hot: %b", layer_status);

endmodule

// ==== hw/layer_sched_pkg.sv ====
`include "page_align_macros.svh"

package layer_sched_pkg;

	// ============================================================
	// layer schedule types
	// ============================================================

	typedef logic [`LAYER_NUM-1:0] layer_status_t; // one-hot, zero when idle.

	// delay applied by a lane this cycle
	typedef enum logic [1:0] {
		delay_none = 2'b00, // live input.
		delay_one  = 2'b01,
		delay_two  = 2'b10
	} delay_cmd_t;

	typedef enum logic [1:0] {
		group_fixed = 2'b00, // always two cycles.
		group_2_3   = 2'b01,
		group_3_2   = 2'b10,
		group_4_1   = 2'b11
	} lane_group_t;

	typedef delay_cmd_t [`LANE_NUM-1:0] lane_cmd_t; // lane 0 in the low bits.

	// ============================================================
	// lane to group table
	// ============================================================

	localparam lane_group_t lane_group_map [`LANE_NUM] = '{
		group_fixed, // lane 0.
		group_fixed,
		group_2_3,   // lanes 2 and 3.
		group_2_3,
		group_fixed,
		group_fixed,
		group_fixed,
		group_fixed,
		group_fixed,
		group_fixed,
		group_4_1,   // lanes 10 and 11.
		group_4_1,
		group_3_2,   // lanes 12 to 15.
		group_3_2,
		group_3_2,
		group_3_2
	};

endpackage

// ==== hw/msg_pkg.sv ====
`include "page_align_macros.svh"

package msg_pkg;

	// ============================================================
	// message types
	// ============================================================

	// one quantized check-node message.
	typedef logic [`QUAN_SIZE-1:0] msg_t;

	// whole bank, lane 0 in the low bits.
	typedef msg_t [`LANE_NUM-1:0] msg_bank_t;

endpackage

// ==== hw/page_align_macros.svh ====
`ifndef PAGE_ALIGN_MACROS_SVH
`define PAGE_ALIGN_MACROS_SVH

// ============================================================
// page alignment sizing
// ============================================================

// bits per quantized check-node message.
`define QUAN_SIZE 4

// message lanes in the bank.
`define LANE_NUM 16

// layers in the schedule, one status bit each.
`define LAYER_NUM 3

// longest lane delay in cycles.
`define ALIGN_DEPTH 2

`endif
